/* hw/eth_fcs_pkg.sv */
package eth_fcs_pkg;

    // stream word geometry
    localparam int DATA_BYTES = 8;

    // byte 0 sits in bits 7:0
    typedef logic [DATA_BYTES*8-1:0] axis_data_t;

    // contiguous byte enables starting at bit 0
    typedef logic [DATA_BYTES-1:0] axis_keep_t;

    typedef logic [31:0] crc_t;

    // frame tracking in the checker
    typedef enum logic [1:0] {
        fcs_idle    = 2'd0,
        fcs_payload = 2'd1,
        fcs_last    = 2'd2
    } fcs_state_t;

    // running CRC starts from all ones
    localparam crc_t CRC_INIT = 32'hffff_ffff;

    // state left behind once a correct FCS has been folded in
    localparam crc_t CRC_RESIDUE = ~32'h2144_df1c;

    // reflected form of 0x04c11db7
    localparam crc_t CRC_POLY = 32'hedb8_8320;

endpackage

/* hw/axis_if.sv */
`timescale 1ns/1ps

interface axis_if
    import eth_fcs_pkg::*;
();

    axis_data_t tdata;
    axis_keep_t tkeep;
    logic       tvalid;
    logic       tready;
    logic       tlast;
    logic       tuser;

    modport source (
        output tdata,
        output tkeep,
        output tvalid,
        input  tready,
        output tlast,
        output tuser
    );

    modport sink (
        input  tdata,
        input  tkeep,
        input  tvalid,
        output tready,
        input  tlast,
        input  tuser
    );

endinterface

/* hw/eth_crc_lanes.sv */
`timescale 1ns/1ps

module eth_crc_lanes
    import eth_fcs_pkg::*;
(
    input  axis_data_t data,
    input  crc_t       crc_in,
    input  crc_t       crc_in_hi,
    input  logic       hi_half,
    output crc_t       crc_1,
    output crc_t       crc_2,
    output crc_t       crc_3,
    output crc_t       crc_4,
    output crc_t       crc_8
);

    axis_data_t lane_data;
    crc_t       lane_state;

    // bit-serial form, unrolled into an XOR network per lane
    function automatic crc_t crc_advance(input crc_t crc, input axis_data_t d,
                                         input int nbytes);
        crc_t c;
        logic fb;
        c = crc;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (i < nbytes) begin
                // lsb first, as on the wire
                for (int b = 0; b < 8; b++) begin
                    fb = c[0] ^ d[8*i+b];
                    c = c >> 1;
                    if (fb) begin
                        c = c ^ CRC_POLY;
                    end
                end
            end
        end
        return c;
    endfunction

    // upper half of the word shifted down for the short lanes
    assign lane_data  = hi_half ? {32'h0, data[63:32]} : data;
    assign lane_state = hi_half ? crc_in_hi : crc_in;

    assign crc_1 = crc_advance(lane_state, lane_data, 1);
    assign crc_2 = crc_advance(lane_state, lane_data, 2);
    assign crc_3 = crc_advance(lane_state, lane_data, 3);
    assign crc_4 = crc_advance(lane_state, lane_data, 4);

    // full word always starts from the running state
    assign crc_8 = crc_advance(crc_in, data, DATA_BYTES);

endmodule

/* hw/axis_eth_fcs_check_64.sv */
`timescale 1ns/1ps

module axis_eth_fcs_check_64
    import eth_fcs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  axis_data_t s_tdata,
    input  axis_keep_t s_tkeep,
    input  logic       s_tvalid,
    output logic       s_tready,
    input  logic       s_tlast,
    input  logic       s_tuser,

    axis_if.source     out,
    input  logic       out_ready_early,

    output logic       busy,
    output logic       error_bad_fcs
);

    fcs_state_t state;
    fcs_state_t state_next;

    // one-word delay line
    axis_data_t data_d0;
    axis_keep_t keep_d0;
    logic       valid_d0;
    logic       tuser_d0;

    crc_t crc_reg;
    crc_t crc_hi_reg;
    crc_t crc_1;
    crc_t crc_2;
    crc_t crc_3;
    crc_t crc_4;
    crc_t crc_8;

    logic       accept;
    logic       in_last;
    logic [3:0] fcs_keep;
    logic       fcs_ok;
    logic       shift;
    logic       flush;
    logic       s_tready_next;
    logic       error_next;

    assign accept  = s_tready & s_tvalid;
    assign in_last = (state == fcs_last);

    eth_crc_lanes u_crc_lanes (
        .data      (in_last ? data_d0 : s_tdata),
        .crc_in    (crc_reg),
        .crc_in_hi (crc_hi_reg),
        .hi_half   (in_last),
        .crc_1     (crc_1),
        .crc_2     (crc_2),
        .crc_3     (crc_3),
        .crc_4     (crc_4),
        .crc_8     (crc_8)
    );

    // bytes of the closing word that hold FCS, relative to the lane base
    assign fcs_keep = in_last ? keep_d0[7:4] : s_tkeep[3:0];

    always_comb begin
        case (fcs_keep)
            4'b0001: fcs_ok = (crc_1 == CRC_RESIDUE);
            4'b0011: fcs_ok = (crc_2 == CRC_RESIDUE);
            4'b0111: fcs_ok = (crc_3 == CRC_RESIDUE);
            4'b1111: fcs_ok = (crc_4 == CRC_RESIDUE);
            default: fcs_ok = 1'b0;
        endcase
    end

    always_comb begin
        state_next    = state;
        s_tready_next = out_ready_early;
        shift         = 1'b0;
        flush         = 1'b0;
        error_next    = 1'b0;

        // by default the delayed word goes out alongside each new input
        out.tdata  = data_d0;
        out.tkeep  = keep_d0;
        out.tvalid = valid_d0 & s_tvalid;
        out.tlast  = 1'b0;
        out.tuser  = 1'b0;

        case (state)
            fcs_idle, fcs_payload: begin
                if (accept) begin
                    shift      = 1'b1;
                    state_next = fcs_payload;
                    if (s_tlast) begin
                        if (s_tkeep[7:4] == 4'b0000) begin
                            // FCS ends in the low half, delayed word closes the frame
                            flush      = 1'b1;
                            out.tlast  = 1'b1;
                            out.tkeep  = {s_tkeep[3:0], 4'b1111};
                            out.tuser  = s_tuser | ~fcs_ok;
                            error_next = valid_d0 & ~fcs_ok;
                            state_next = fcs_idle;
                        end else begin
                            // payload spills into the new word, one more beat needed
                            s_tready_next = 1'b0;
                            state_next    = fcs_last;
                        end
                    end
                end
            end
            fcs_last: begin
                s_tready_next = 1'b0;
                out.tkeep     = {4'b0000, keep_d0[7:4]};
                out.tvalid    = valid_d0;
                out.tlast     = 1'b1;
                out.tuser     = tuser_d0 | ~fcs_ok;
                if (out.tready) begin
                    flush         = 1'b1;
                    error_next    = ~fcs_ok;
                    s_tready_next = out_ready_early;
                    state_next    = fcs_idle;
                end
            end
            default: begin
                state_next = fcs_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= fcs_idle;
            s_tready      <= 1'b0;
            busy          <= 1'b0;
            error_bad_fcs <= 1'b0;
            valid_d0      <= 1'b0;
            crc_reg       <= CRC_INIT;
            crc_hi_reg    <= CRC_INIT;
        end else begin
            state         <= state_next;
            s_tready      <= s_tready_next;
            busy          <= (state_next != fcs_idle);
            error_bad_fcs <= error_next;

            if (flush) begin
                valid_d0   <= 1'b0;
                crc_reg    <= CRC_INIT;
                crc_hi_reg <= CRC_INIT;
            end else if (shift) begin
                valid_d0   <= 1'b1;
                crc_reg    <= crc_8;
                // state after the low half, for an FCS in the upper half
                crc_hi_reg <= crc_4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            data_d0  <= s_tdata;
            keep_d0  <= s_tkeep;
            tuser_d0 <= s_tuser;
        end
    end

endmodule

/* hw/axis_skid_buffer.sv */
`timescale 1ns/1ps

module axis_skid_buffer
    import eth_fcs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    axis_if.sink       in,
    output logic       ready_early,

    output axis_data_t m_tdata,
    output axis_keep_t m_tkeep,
    output logic       m_tvalid,
    output logic       m_tlast,
    output logic       m_tuser,
    input  logic       m_tready
);

    logic       ready_reg;

    // spare slot catches the word that arrives while ready is still high
    axis_data_t spare_tdata;
    axis_keep_t spare_tkeep;
    logic       spare_tvalid;
    logic       spare_tlast;
    logic       spare_tuser;

    logic load_out;
    logic load_spare;
    logic move_spare;

    assign in.tready = ready_reg;

    // room next cycle unless both slots could end up full
    assign ready_early = m_tready | (~spare_tvalid & (~m_tvalid | ~in.tvalid));

    assign load_out   = ready_reg & (m_tready | ~m_tvalid);
    assign load_spare = ready_reg & m_tvalid & ~m_tready;
    assign move_spare = ~ready_reg & m_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg    <= 1'b0;
            m_tvalid     <= 1'b0;
            spare_tvalid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (load_out) begin
                m_tvalid <= in.tvalid;
            end else if (move_spare) begin
                m_tvalid     <= spare_tvalid;
                spare_tvalid <= 1'b0;
            end
            if (load_spare) begin
                spare_tvalid <= in.tvalid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            m_tdata <= in.tdata;
            m_tkeep <= in.tkeep;
            m_tlast <= in.tlast;
            m_tuser <= in.tuser;
        end else if (move_spare) begin
            m_tdata <= spare_tdata;
            m_tkeep <= spare_tkeep;
            m_tlast <= spare_tlast;
            m_tuser <= spare_tuser;
        end
        if (load_spare) begin
            spare_tdata <= in.tdata;
            spare_tkeep <= in.tkeep;
            spare_tlast <= in.tlast;
            spare_tuser <= in.tuser;
        end
    end

endmodule

/* hw/fcs_check_top.sv */
`timescale 1ns/1ps

module fcs_check_top
    import eth_fcs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  axis_data_t s_tdata,
    input  axis_keep_t s_tkeep,
    input  logic       s_tvalid,
    output logic       s_tready,
    input  logic       s_tlast,
    input  logic       s_tuser,

    output axis_data_t m_tdata,
    output axis_keep_t m_tkeep,
    output logic       m_tvalid,
    input  logic       m_tready,
    output logic       m_tlast,
    output logic       m_tuser,

    output logic       busy,
    output logic       error_bad_fcs
);

    logic ready_early;

    // checked words, FCS bytes already stripped
    axis_if checked ();

    axis_eth_fcs_check_64 u_check (
        .clk             (clk),
        .rst             (rst),
        .s_tdata         (s_tdata),
        .s_tkeep         (s_tkeep),
        .s_tvalid        (s_tvalid),
        .s_tready        (s_tready),
        .s_tlast         (s_tlast),
        .s_tuser         (s_tuser),
        .out             (checked.source),
        .out_ready_early (ready_early),
        .busy            (busy),
        .error_bad_fcs   (error_bad_fcs)
    );

    axis_skid_buffer u_skid (
        .clk         (clk),
        .rst         (rst),
        .in          (checked.sink),
        .ready_early (ready_early),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tvalid    (m_tvalid),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser),
        .m_tready    (m_tready)
    );

endmodule

/* bench/fcs_check_assertions.sv */
`timescale 1ns/1ps

module fcs_check_assertions
    import eth_fcs_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       s_tready,
    input axis_data_t m_tdata,
    input axis_keep_t m_tkeep,
    input logic       m_tvalid,
    input logic       m_tready,
    input logic       m_tlast,
    input logic       m_tuser,
    input logic       busy,
    input logic       error_bad_fcs,
    input logic       last_handoff
);

    int fail_count = 0;

    a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(m_tvalid))
    else begin
        $error("m_tvalid is unknown after reset");
        fail_count++;
    end

    // stalled output word must not move
    a_hold_stall: assert property (@(posedge clk) disable iff (rst)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
                                     && $stable(m_tlast) && $stable(m_tuser)))
    else begin
        $error("output changed while stalled");
        fail_count++;
    end

    a_pulse_source: assert property (@(posedge clk) disable iff (rst)
        error_bad_fcs |-> ($past(last_handoff) ##1 !error_bad_fcs))
    else begin
        $error("error_bad_fcs not a single pulse after a last-word handoff");
        fail_count++;
    end

    // one edge into reset everything reads idle
    a_reset_idle: assert property (@(posedge clk)
        rst |=> (!busy && !m_tvalid && !s_tready && !error_bad_fcs))
    else begin
        $error("busy, valid or ready high during reset");
        fail_count++;
    end

endmodule

/* bench/tb_fcs_check.sv */
`timescale 1ns/1ps

module tb_fcs_check
    import eth_fcs_pkg::*;
();

    localparam int N_BAD = 8;
    localparam int N_USER = 4;
    localparam int N_BP = 40;
    // lengths 9..72 once, every other frame at most 72 bytes
    localparam int MAX_BYTES = 2592 + (N_BAD + N_USER + N_BP) * 72;
    localparam int WATCHDOG_CYCLES = MAX_BYTES * 4 + 2000;
    localparam int DRAIN_CYCLES = 2000;

    logic       clk = 1'b0;
    logic       rst;
    axis_data_t s_tdata;
    axis_keep_t s_tkeep;
    logic       s_tvalid;
    logic       s_tready;
    logic       s_tlast;
    logic       s_tuser;
    axis_data_t m_tdata;
    axis_keep_t m_tkeep;
    logic       m_tvalid;
    logic       m_tready = 1'b0;
    logic       m_tlast;
    logic       m_tuser;
    logic       busy;
    logic       error_bad_fcs;

    integer gen_seed = 32'h1833;
    integer ready_seed = 32'h1833;
    logic   backpressure = 1'b0;

    // expected payload bytes, flat, plus length and tuser per frame
    logic [7:0] exp_bytes [$];
    int         exp_len [$];
    logic       exp_user [$];
    logic [7:0] got_bytes [$];

    string test_name = "none";
    int    errors = 0;
    int    tests_run = 0;
    int    frames_checked = 0;
    int    pulses = 0;
    int    exp_pulses = 0;
    int    errors_at_start;
    int    frames_at_start;
    int    pulses_at_start;

    always #20 clk = ~clk;

    fcs_check_top UUT (
        .clk(clk), .rst(rst),
        .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid),
        .s_tready(s_tready), .s_tlast(s_tlast), .s_tuser(s_tuser),
        .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid),
        .m_tready(m_tready), .m_tlast(m_tlast), .m_tuser(m_tuser),
        .busy(busy), .error_bad_fcs(error_bad_fcs)
    );

    bind fcs_check_top fcs_check_assertions u_assertions (
        .clk(clk), .rst(rst), .s_tready(s_tready),
        .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid), .m_tready(m_tready),
        .m_tlast(m_tlast), .m_tuser(m_tuser), .busy(busy), .error_bad_fcs(error_bad_fcs),
        .last_handoff(checked.tvalid & checked.tready & checked.tlast)
    );

    function automatic int pick_below(input int range);
        int r;
        r = $random(gen_seed) & 32'h7fff_ffff;
        return r % range;
    endfunction

    // bit-serial CRC-32, lsb first
    function automatic crc_t crc_byte(input crc_t crc, input logic [7:0] b);
        crc_t c;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            if (c[0] ^ b[k]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        errors++;
    endtask

    // bad_pos < 0 leaves the frame intact
    task automatic send_frame(input int len, input int bad_pos, input logic user_last);
        logic [7:0] tx [$];
        crc_t       crc;
        int         nwords;
        int         n;
        logic       rdy;
        crc = CRC_INIT;
        for (int i = 0; i < len - 4; i++) begin
            tx.push_back(8'($random(gen_seed)));
            crc = crc_byte(crc, tx[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            tx.push_back(crc[8*i +: 8]);
        end
        if (bad_pos >= 0) begin
            tx[bad_pos] = tx[bad_pos] ^ 8'h5a;
            exp_pulses++;
        end
        for (int i = 0; i < len - 4; i++) begin
            exp_bytes.push_back(tx[i]);
        end
        exp_len.push_back(len - 4);
        exp_user.push_back(user_last | (bad_pos >= 0));
        nwords = (len + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            n = (len - 8*w > 8) ? 8 : len - 8*w;
            s_tdata = '0;
            for (int b = 0; b < n; b++) begin
                s_tdata[8*b +: 8] = tx[8*w + b];
            end
            s_tkeep = 8'hff >> (8 - n);
            s_tvalid = 1'b1;
            s_tlast = (w == nwords - 1);
            s_tuser = s_tlast & user_last;
            do begin
                @(negedge clk);
                rdy = s_tready;
                @(posedge clk);
                #2;
            end while (!rdy);
            if (w != nwords - 1) begin
                assert (busy == 1'b1) else report_mismatch("busy mid-frame", 64'(1), 64'(busy));
            end
        end
    endtask

    task automatic check_frame();
        int   len;
        int   first_bad;
        logic exp_u;
        if (exp_len.size() == 0) begin
            $display("%s: output frame of %0d bytes with nothing expected", test_name,
                     got_bytes.size());
            errors++;
        end else begin
            len = exp_len.pop_front();
            exp_u = exp_user.pop_front();
            assert (got_bytes.size() == len)
            else report_mismatch("frame length", 64'(len), 64'(got_bytes.size()));
            first_bad = -1;
            for (int i = 0; i < len && i < got_bytes.size(); i++) begin
                if (first_bad < 0 && got_bytes[i] !== exp_bytes[i]) begin
                    first_bad = i;
                end
            end
            assert (first_bad < 0)
            else report_mismatch($sformatf("byte %0d", first_bad), 64'(exp_bytes[first_bad]),
                                 64'(got_bytes[first_bad]));
            assert (m_tuser == exp_u) else report_mismatch("tuser", 64'(exp_u), 64'(m_tuser));
            for (int i = 0; i < len; i++) begin
                void'(exp_bytes.pop_front());
            end
        end
        got_bytes = {};
        frames_checked++;
    endtask

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (error_bad_fcs) begin
                pulses++;
            end
            if (m_tvalid && m_tready) begin
                for (int b = 0; b < DATA_BYTES; b++) begin
                    if (m_tkeep[b]) begin
                        got_bytes.push_back(m_tdata[8*b +: 8]);
                    end
                end
                if (m_tlast) begin
                    check_frame();
                end
            end
        end
    end

    always @(posedge clk) begin
        #2;
        m_tready = backpressure ? (($random(ready_seed) & 3) != 0) : 1'b1;
    end

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
        frames_at_start = frames_checked;
        pulses_at_start = pulses;
        exp_pulses = 0;
    endtask

    task automatic finish_test();
        int waited;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        waited = 0;
        while (exp_len.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (exp_len.size() != 0) begin
            $display("%s: %0d frames never came out", test_name, exp_len.size());
            errors++;
            exp_len = {};
            exp_user = {};
            exp_bytes = {};
        end
        repeat (4) @(posedge clk);
        #2;
        assert (pulses - pulses_at_start == exp_pulses)
        else report_mismatch("bad FCS pulses", 64'(exp_pulses), 64'(pulses - pulses_at_start));
        tests_run++;
        $display("test %s done: %0d frames, %0d errors", test_name,
                 frames_checked - frames_at_start, errors - errors_at_start);
    endtask

    initial begin
        int len;
        int pos;
        rst = 1'b1;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("reset_state");
        assert (!s_tready) else report_mismatch("s_tready", 64'(0), 64'(s_tready));
        assert (!m_tvalid) else report_mismatch("m_tvalid", 64'(0), 64'(m_tvalid));
        assert (!busy) else report_mismatch("busy", 64'(0), 64'(busy));
        assert (!error_bad_fcs) else report_mismatch("error_bad_fcs", 64'(0), 64'(error_bad_fcs));
        finish_test();

        // every end-byte position
        start_test("good_lengths");
        for (int l = 9; l <= 72; l++) begin
            send_frame(l, -1, 1'b0);
        end
        finish_test();

        // even frames hit the payload, odd ones the FCS
        start_test("bad_fcs");
        for (int i = 0; i < N_BAD; i++) begin
            len = 9 + pick_below(64);
            pos = (i % 2 == 0) ? pick_below(len - 4) : len - 4 + pick_below(4);
            send_frame(len, pos, 1'b0);
        end
        finish_test();

        start_test("tuser_passthrough");
        for (int i = 0; i < N_USER; i++) begin
            send_frame(9 + pick_below(64), -1, 1'b1);
        end
        finish_test();

        start_test("backpressure");
        backpressure = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            len = 9 + pick_below(64);
            pos = (pick_below(4) == 0) ? pick_below(len) : -1;
            send_frame(len, pos, pick_below(8) == 0);
        end
        finish_test();
        backpressure = 1'b0;

        errors = errors + UUT.u_assertions.fail_count;
        $display("tests %0d, frames checked %0d, assertion failures %0d, errors %0d", tests_run,
                 frames_checked, UUT.u_assertions.fail_count, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* filelist.f */
hw/eth_fcs_pkg.sv
hw/axis_if.sv
hw/eth_crc_lanes.sv
hw/axis_eth_fcs_check_64.sv
hw/axis_skid_buffer.sv
hw/fcs_check_top.sv
bench/fcs_check_assertions.sv
bench/tb_fcs_check.sv

/* Makefile */
# Verilator build and run for the FCS check testbench

VERILATOR ?= verilator
TOP       ?= tb_fcs_check
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j 0

FAIL_MSG := FAIL: see errors above
PASS_MSG := PASS: all tests
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
